// ==== conv7_top.f ====
hdl/conv_pkg.sv
hdl/kernel_row_mac.sv
hdl/psum_quant.sv
hdl/conv7_ctrl.sv
hdl/conv7_top.sv
bench/conv7_checker.sv
bench/tb_conv7.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_conv7
FILELIST  ?= conv7_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only if the pass message shows up on a line of its own
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_conv7.sv ====
`timescale 1ns/100ps

module tb_conv7;

    localparam int IMG_W_WORDS = 4;
    localparam int IMG_H       = 10;
    localparam int NUM_CH      = 2;
    localparam int NUM_RUNS    = 5;
    localparam int MEM_WORDS   = 1 << conv_pkg::ADDR_W;
    localparam int WT_WORDS    = 2 * 7 * NUM_CH;
    localparam int IMG_WORDS   = IMG_H * IMG_W_WORDS;
    localparam int CYCLE_LIMIT = NUM_CH * (40 + 21 * IMG_WORDS) * NUM_RUNS + 200;

    // stimulus shapes for weight and image bytes
    localparam int RAND_DATA  = 0;
    localparam int NEG_DATA   = 1;
    localparam int POS_DATA   = 2;
    localparam int LARGE_DATA = 3;
    localparam int CORNERS    = 4;

    logic                 clk;
    logic                 rst_n;
    logic                 start;
    conv_pkg::conv_cfg_t  cfg;
    logic                 finish;
    conv_pkg::mem_rd_t    wt_rd;
    logic [63:0]          wt_rdata = '0;
    conv_pkg::mem_rd_t    act_rd;
    conv_pkg::act_word_u  act_rdata = '0;
    conv_pkg::out_wr_t    out_wr;

    logic [31:0] wt_mem  [MEM_WORDS];
    logic [31:0] act_mem [MEM_WORDS];
    logic [31:0] rng;
    int          cycles;
    int          value_errs;
    int          count_errs;
    int          proto_errs;

    conv7_top #(
        .IMG_W_WORDS (IMG_W_WORDS),
        .IMG_H       (IMG_H),
        .NUM_CH      (NUM_CH)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .cfg       (cfg),
        .finish    (finish),
        .wt_rd     (wt_rd),
        .wt_rdata  (wt_rdata),
        .act_rd    (act_rd),
        .act_rdata (act_rdata),
        .out_wr    (out_wr)
    );

    conv7_checker #(
        .IMG_W_WORDS (IMG_W_WORDS),
        .IMG_H       (IMG_H),
        .NUM_CH      (NUM_CH),
        .MEM_WORDS   (MEM_WORDS)
    ) i_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .finish     (finish),
        .cfg        (cfg),
        .wt_rd      (wt_rd),
        .act_rd     (act_rd),
        .out_wr     (out_wr),
        .wt_mem     (wt_mem),
        .act_mem    (act_mem),
        .value_errs (value_errs),
        .count_errs (count_errs),
        .proto_errs (proto_errs)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // synchronous memories with one cycle of read latency
    always @(posedge clk) begin
        if (wt_rd.en)
            wt_rdata <= {wt_mem[wt_rd.addr + 16'd1], wt_mem[wt_rd.addr]};
        if (act_rd.en)
            act_rdata.raw <= act_mem[act_rd.addr];
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [7:0] shape_byte(logic [7:0] r, int mode);
        case (mode)
            NEG_DATA:   return {1'b1, r[6:0]};          // -128 .. -1
            POS_DATA:   return {1'b0, r[6:0]} | 8'd1;   // 1 .. 127
            LARGE_DATA: return 8'd100 + r % 8'd28;
            default:    return r;
        endcase
    endfunction

    task automatic load_weights(input logic [15:0] base, input int mode);
        logic [31:0] w;
        for (int i = 0; i < WT_WORDS; i++) begin
            rng = xorshift32(rng);
            for (int b = 0; b < 4; b++)
                w[8*b +: 8] = shape_byte(rng[8*b +: 8], mode);
            wt_mem[base + 16'(i)] = w;
        end
    endtask

    task automatic load_image(input logic [15:0] base, input int mode);
        logic [31:0] w;
        for (int i = 0; i < IMG_WORDS; i++) begin
            rng = xorshift32(rng);
            for (int b = 0; b < 4; b++)
                w[8*b +: 8] = (mode == CORNERS) ? 8'd0 : shape_byte(rng[8*b +: 8], mode);
            act_mem[base + 16'(i)] = w;
        end
        if (mode == CORNERS) begin
            act_mem[base][7:0] = 8'd90;                       // top left
            act_mem[base + 16'(IMG_WORDS - 1)][31:24] = 8'hA6; // bottom right pixel at -90
        end
    endtask

    task automatic run_conv(input conv_pkg::conv_cfg_t c);
        @(negedge clk);
        cfg   = c;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!finish)
            @(negedge clk);
        @(negedge clk);
    endtask

    task automatic report_counts();
        $display("errors: %0d value, %0d write count, %0d protocol",
                 value_errs, count_errs, proto_errs);
    endtask

    always @(posedge clk) begin
        if (!rst_n)
            cycles <= 0;
        else
            cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles, finish never came", cycles);
            report_counts();
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        conv_pkg::conv_cfg_t c;
        rst_n = 1'b0;
        start = 1'b0;
        cfg   = '0;
        rng   = 32'd20;
        for (int a = 0; a < MEM_WORDS; a++) begin
            wt_mem[a]  = {16'(a), ~16'(a)} ^ 32'h3C3C_0000;
            act_mem[a] = {~16'(a), 16'(a)};
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (10) @(negedge clk); // enables must stay low while idle

        c = '{act_base: 16'h0100, weight_base: 16'h0040, out_base: 16'h2000, scale: 16'd16};
        load_weights(c.weight_base, RAND_DATA);
        load_image(c.act_base, RAND_DATA);
        run_conv(c);

        c.scale = 16'd512; // one tap lands near sum/128
        load_weights(c.weight_base, RAND_DATA);
        load_image(c.act_base, CORNERS);
        run_conv(c);

        c.scale = 16'd1000;
        load_weights(c.weight_base, NEG_DATA);
        load_image(c.act_base, POS_DATA);
        run_conv(c);

        c.scale = 16'hFFFF;
        load_weights(c.weight_base, LARGE_DATA);
        load_image(c.act_base, LARGE_DATA);
        run_conv(c);

        c = '{act_base: 16'h3000, weight_base: 16'h0800, out_base: 16'h5000, scale: 16'd40};
        load_weights(c.weight_base, RAND_DATA);
        load_image(c.act_base, RAND_DATA);
        run_conv(c);

        repeat (2) @(negedge clk);
        report_counts();
        if (value_errs + count_errs + proto_errs == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== bench/conv7_checker.sv ====
`timescale 1ns/100ps

module conv7_checker #(
    parameter int IMG_W_WORDS = 4,
    parameter int IMG_H       = 10,
    parameter int NUM_CH      = 2,
    parameter int MEM_WORDS   = 65536
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 finish,
    input  conv_pkg::conv_cfg_t  cfg,
    input  conv_pkg::mem_rd_t    wt_rd,
    input  conv_pkg::mem_rd_t    act_rd,
    input  conv_pkg::out_wr_t    out_wr,
    input  logic [31:0]          wt_mem  [MEM_WORDS],
    input  logic [31:0]          act_mem [MEM_WORDS],
    output int                   value_errs,
    output int                   count_errs,
    output int                   proto_errs
);

    localparam int KSIZE = 7;
    localparam int PLANE = IMG_H * IMG_W_WORDS;
    localparam int OUT_WORDS = NUM_CH * PLANE;

    int   wr_cnt [OUT_WORDS];
    int   runs;
    logic busy;
    logic start_q;
    logic finish_prev;

    // zero outside the image
    function automatic int pixel_at(int y, int x);
        logic [15:0] a;
        logic [31:0] w;
        if (y < 0 || y >= IMG_H || x < 0 || x >= 4 * IMG_W_WORDS)
            return 0;
        a = cfg.act_base + 16'(y * IMG_W_WORDS + x / 4);
        w = act_mem[a];
        return int'($signed(w[8*(x%4) +: 8]));
    endfunction

    function automatic int weight_at(int ch, int r, int k);
        logic [15:0] a;
        logic [31:0] w;
        a = cfg.weight_base + 16'(14 * ch + 2 * r + k / 4);
        w = wt_mem[a];
        return int'($signed(w[8*(k%4) +: 8]));
    endfunction

    function automatic logic [7:0] expected_pixel(int ch, int y, int x);
        int     sum;
        longint scaled;
        sum = 0;
        for (int r = 0; r < KSIZE; r++)
            for (int k = 0; k < KSIZE; k++)
                sum += weight_at(ch, r, k) * pixel_at(y + r - 3, x + k - 3);
        if (sum <= 0)
            return 8'd0;
        scaled = (longint'(sum) * longint'(cfg.scale)) >>> 16;
        if (scaled > 127)
            return 8'd127;
        return 8'(scaled);
    endfunction

    function automatic logic [31:0] expected_word(int ch, int y, int c);
        logic [31:0] w;
        for (int j = 0; j < 4; j++)
            w[8*j +: 8] = expected_pixel(ch, y, 4 * c + j);
        return w;
    endfunction

    task automatic check_write();
        logic [15:0] diff;
        logic [31:0] want;
        int          off;
        diff = out_wr.addr - cfg.out_base;
        off  = int'(diff);
        if (off >= OUT_WORDS) begin
            $display("write to address %h lies outside the output planes", out_wr.addr);
            proto_errs++;
        end else begin
            want = expected_word(off / PLANE, (off % PLANE) / IMG_W_WORDS, off % IMG_W_WORDS);
            if (out_wr.data.raw !== want) begin
                $display("FAIL %0t out_wr.data expected %h got %h (addr %h)",
                         $time, want, out_wr.data.raw, out_wr.addr);
                value_errs++;
            end
            wr_cnt[off]++;
        end
    endtask

    // every output word exactly once per run
    task automatic close_run();
        for (int i = 0; i < OUT_WORDS; i++) begin
            if (wr_cnt[i] != 1) begin
                $display("output word %0d of run %0d written %0d times", i, runs, wr_cnt[i]);
                count_errs++;
            end
            wr_cnt[i] = 0;
        end
        runs++;
    endtask

    always @(posedge clk)
        start_q <= start; // the cycle the DUT takes start

    always @(negedge clk) begin
        if (!rst_n) begin
            value_errs  = 0;
            count_errs  = 0;
            proto_errs  = 0;
            runs        = 0;
            busy        = 1'b0;
            finish_prev = 1'b0;
            for (int i = 0; i < OUT_WORDS; i++)
                wr_cnt[i] = 0;
        end else begin
            if (start_q)
                busy = 1'b1;
            if (!busy && (wt_rd.en || act_rd.en || out_wr.en || finish)) begin
                $display("DUT active without a start at %0t", $time);
                proto_errs++;
            end
            if (out_wr.en)
                check_write();
            if (finish && finish_prev) begin
                $display("finish stayed high for more than one cycle at %0t", $time);
                proto_errs++;
            end
            if (finish && !finish_prev && busy) begin
                close_run();
                busy = 1'b0;
            end
            finish_prev = finish;
        end
    end

endmodule

// ==== hdl/conv7_top.sv ====
`timescale 1ns/100ps

module conv7_top #(
    parameter int IMG_W_WORDS = 4,
    parameter int IMG_H       = 10,
    parameter int NUM_CH      = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  conv_pkg::conv_cfg_t   cfg,
    output logic                  finish,
    output conv_pkg::mem_rd_t     wt_rd,
    input  logic [63:0]           wt_rdata,
    output conv_pkg::mem_rd_t     act_rd,
    input  conv_pkg::act_word_u   act_rdata,
    output conv_pkg::out_wr_t     out_wr
);

    conv_pkg::wt_tag_t                                 wt_tag;
    conv_pkg::row_tag_t                                row_tag;
    conv_pkg::psum_t [conv_pkg::PIX_PER_WORD-1:0]      psum;
    logic                                              psum_valid;
    logic [2:0]                                        psum_krow;
    logic                                              psum_last;
    logic [conv_pkg::ADDR_W-1:0]                       psum_addr;

    conv7_ctrl #(
        .IMG_W_WORDS (IMG_W_WORDS),
        .IMG_H       (IMG_H),
        .NUM_CH      (NUM_CH)
    ) i_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .cfg     (cfg),
        .finish  (finish),
        .wt_rd   (wt_rd),
        .wt_tag  (wt_tag),
        .act_rd  (act_rd),
        .row_tag (row_tag)
    );

    kernel_row_mac i_mac (
        .clk        (clk),
        .rst_n      (rst_n),
        .wt_rdata   (wt_rdata),
        .wt_tag     (wt_tag),
        .act_rdata  (act_rdata),
        .row_tag    (row_tag),
        .psum       (psum),
        .psum_valid (psum_valid),
        .psum_krow  (psum_krow),
        .psum_last  (psum_last),
        .psum_addr  (psum_addr)
    );

    psum_quant i_quant (
        .clk        (clk),
        .rst_n      (rst_n),
        .scale      (cfg.scale),
        .psum       (psum),
        .psum_valid (psum_valid),
        .psum_krow  (psum_krow),
        .psum_last  (psum_last),
        .psum_addr  (psum_addr),
        .out_wr     (out_wr)
    );

endmodule

// ==== hdl/conv7_ctrl.sv ====
`timescale 1ns/100ps

module conv7_ctrl #(
    parameter int IMG_W_WORDS = 4,
    parameter int IMG_H       = 10,
    parameter int NUM_CH      = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  conv_pkg::conv_cfg_t  cfg,
    output logic                 finish,
    output conv_pkg::mem_rd_t    wt_rd,
    output conv_pkg::wt_tag_t    wt_tag,
    output conv_pkg::mem_rd_t    act_rd,
    output conv_pkg::row_tag_t   row_tag
);

    typedef logic [conv_pkg::ADDR_W-1:0] addr_t;
    typedef enum logic [2:0] {IDLE, LOAD_WT, STREAM, DRAIN, DONE} state_t;

    localparam int PLANE     = IMG_H * IMG_W_WORDS;
    localparam int WT_PER_CH = 2 * conv_pkg::KERNEL; // two words per kernel row
    localparam logic [2:0] LAST_KROW = 3'(conv_pkg::KERNEL - 1);

    state_t      state;
    logic [15:0] ch;
    logic [15:0] oy;
    logic [15:0] ox;
    logic [2:0]  wt_cnt;
    logic [2:0]  krow;
    logic [1:0]  slot;
    logic [1:0]  drain_cnt;
    logic        last_slot;
    logic        last_group;
    int          iy;
    int          ix;

    assign last_slot  = (slot == 2'd2) && (krow == LAST_KROW);
    assign last_group = last_slot && (ox == 16'(IMG_W_WORDS - 1)) && (oy == 16'(IMG_H - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            ch        <= '0;
            oy        <= '0;
            ox        <= '0;
            wt_cnt    <= '0;
            krow      <= '0;
            slot      <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state  <= LOAD_WT;
                        ch     <= '0;
                        wt_cnt <= '0;
                    end
                end
                LOAD_WT: begin
                    wt_cnt <= wt_cnt + 3'd1;
                    if (wt_cnt == LAST_KROW) begin
                        state <= STREAM;
                        oy    <= '0;
                        ox    <= '0;
                        krow  <= '0;
                        slot  <= '0;
                    end
                end
                STREAM: begin
                    if (slot == 2'd2) begin
                        slot <= '0;
                        if (krow == LAST_KROW) begin
                            krow <= '0;
                            if (ox == 16'(IMG_W_WORDS - 1)) begin
                                ox <= '0;
                                oy <= oy + 16'd1;
                            end else begin
                                ox <= ox + 16'd1;
                            end
                        end else begin
                            krow <= krow + 3'd1;
                        end
                    end else begin
                        slot <= slot + 2'd1;
                    end
                    if (last_group) begin
                        state     <= DRAIN;
                        drain_cnt <= '0;
                    end
                end
                DRAIN: begin
                    drain_cnt <= drain_cnt + 2'd1;
                    if (drain_cnt == 2'd2) begin // groups in flight have left the pipe
                        wt_cnt <= '0;
                        if (ch == 16'(NUM_CH - 1)) begin
                            state <= DONE;
                        end else begin
                            ch    <= ch + 16'd1;
                            state <= LOAD_WT;
                        end
                    end
                end
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // address generation holds every bounds test
    always_comb begin
        iy = int'(oy) + int'(krow) - 3;
        ix = int'(ox) + int'(slot) - 1;

        wt_rd.en     = (state == LOAD_WT);
        wt_rd.addr   = cfg.weight_base + addr_t'(WT_PER_CH * int'(ch) + 2 * int'(wt_cnt));
        wt_tag.valid = wt_rd.en;
        wt_tag.krow  = wt_cnt;

        row_tag.valid    = (state == STREAM);
        row_tag.pad      = (iy < 0) || (iy >= IMG_H) || (ix < 0) || (ix >= IMG_W_WORDS);
        row_tag.slot     = slot;
        row_tag.krow     = krow;
        row_tag.last_row = (krow == LAST_KROW);
        row_tag.out_addr = cfg.out_base
                         + addr_t'(PLANE * int'(ch) + IMG_W_WORDS * int'(oy) + int'(ox));

        act_rd.en   = row_tag.valid && !row_tag.pad;
        act_rd.addr = cfg.act_base + addr_t'(iy * IMG_W_WORDS + ix);
    end

    assign finish = (state == DONE);

    // reads stay inside the input plane
    assert property (@(posedge clk) disable iff (!rst_n)
        act_rd.en |-> addr_t'(act_rd.addr - cfg.act_base) < addr_t'(PLANE));

    // one pulse per run
    assert property (@(posedge clk) disable iff (!rst_n)
        finish |=> !finish);

endmodule

// ==== hdl/psum_quant.sv ====
`timescale 1ns/100ps

module psum_quant (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [15:0]                                   scale,
    input  conv_pkg::psum_t [conv_pkg::PIX_PER_WORD-1:0]  psum,
    input  logic                                          psum_valid,
    input  logic [2:0]                                    psum_krow,
    input  logic                                          psum_last,
    input  logic [conv_pkg::ADDR_W-1:0]                   psum_addr,
    output conv_pkg::out_wr_t                             out_wr
);

    localparam int PPW = conv_pkg::PIX_PER_WORD;

    conv_pkg::psum_t [PPW-1:0]    acc;
    conv_pkg::psum_t [PPW-1:0]    total;
    conv_pkg::act_word_u          quant_word;
    logic                         wr_en_q;
    logic [conv_pkg::ADDR_W-1:0]  wr_addr_q;
    conv_pkg::act_word_u          wr_data_q;

    // relu, scale, shift, clamp to int8
    function automatic conv_pkg::pixel_t quantize(conv_pkg::psum_t s, logic [15:0] sc);
        logic [47:0] prod;
        logic [47:0] shifted;
        prod    = {16'd0, s} * {32'd0, sc};
        shifted = prod >> conv_pkg::QUANT_SHIFT;
        if (s <= 0)
            return 8'sd0;
        else if (shifted > 48'd127)
            return 8'sd127;
        else
            return conv_pkg::pixel_t'(shifted[7:0]);
    endfunction

    always_comb begin
        for (int j = 0; j < PPW; j++) begin
            total[j]          = (psum_krow == 3'd0) ? psum[j] : acc[j] + psum[j];
            quant_word.pix[j] = quantize(total[j], scale);
        end
    end

    always_ff @(posedge clk) begin
        if (psum_valid)
            acc <= total; // krow 0 restarts the sum
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            wr_en_q <= 1'b0;
        else
            wr_en_q <= psum_valid && psum_last;
    end

    always_ff @(posedge clk) begin
        if (psum_valid && psum_last) begin
            wr_addr_q <= psum_addr;
            wr_data_q <= quant_word;
        end
    end

    assign out_wr = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

    // a write closes a full stack of kernel rows
    assert property (@(posedge clk) disable iff (!rst_n)
        out_wr.en |-> $past(psum_valid && psum_last, 1)
                   && $past(psum_valid && psum_krow == 3'd0,
                            3 * (conv_pkg::KERNEL - 1) + 1));

endmodule

// ==== hdl/kernel_row_mac.sv ====
`timescale 1ns/100ps

module kernel_row_mac (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [63:0]                                   wt_rdata,
    input  conv_pkg::wt_tag_t                             wt_tag,
    input  conv_pkg::act_word_u                           act_rdata,
    input  conv_pkg::row_tag_t                            row_tag,
    output conv_pkg::psum_t [conv_pkg::PIX_PER_WORD-1:0]  psum,
    output logic                                          psum_valid,
    output logic [2:0]                                    psum_krow,
    output logic                                          psum_last,
    output logic [conv_pkg::ADDR_W-1:0]                   psum_addr
);

    localparam int PPW = conv_pkg::PIX_PER_WORD;

    conv_pkg::wt_tag_t      wt_tag_d;
    conv_pkg::row_tag_t     tag_d;    // lines up with rdata
    conv_pkg::row_tag_t     tag_q;    // lines up with the window
    conv_pkg::kernel_row_t  kernel [conv_pkg::KERNEL];
    conv_pkg::act_word_u    win [3];
    conv_pkg::pixel_t       pix [3*PPW];
    conv_pkg::kernel_row_t  cur_row;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wt_tag_d <= '0;
            tag_d    <= '0;
            tag_q    <= '0;
        end else begin
            wt_tag_d <= wt_tag;
            tag_d    <= row_tag;
            tag_q    <= tag_d;
        end
    end

    // columns 0..3 from word addr, 4..6 from addr+1
    always_ff @(posedge clk) begin
        if (wt_tag_d.valid)
            kernel[wt_tag_d.krow] <= wt_rdata[conv_pkg::KERNEL*8-1:0];
    end

    always_ff @(posedge clk) begin
        if (tag_d.valid) begin
            win[0]     <= win[1];
            win[1]     <= win[2];
            win[2].raw <= tag_d.pad ? 32'd0 : act_rdata.raw;
        end
    end

    always_comb begin
        for (int w = 0; w < 3; w++)
            for (int k = 0; k < PPW; k++)
                pix[w*PPW + k] = win[w].pix[k];
        cur_row = kernel[tag_q.krow];
        for (int j = 0; j < PPW; j++) begin
            psum[j] = '0;
            // centre pixel 4+j, taps reach 3 either side
            for (int k = 0; k < conv_pkg::KERNEL; k++)
                psum[j] = psum[j]
                        + conv_pkg::psum_t'(cur_row[k]) * conv_pkg::psum_t'(pix[j + k + 1]);
        end
    end

    assign psum_valid = tag_q.valid && (tag_q.slot == 2'd2);
    assign psum_krow  = tag_q.krow;
    assign psum_last  = tag_q.last_row;
    assign psum_addr  = tag_q.out_addr;

    // window must hold left and centre of the same kernel row
    assert property (@(posedge clk) disable iff (!rst_n)
        psum_valid |-> $past(tag_q.valid, 1) && $past(tag_q.valid, 2)
                    && $past(tag_q.slot, 1) == 2'd1 && $past(tag_q.slot, 2) == 2'd0
                    && $past(tag_q.krow, 1) == tag_q.krow
                    && $past(tag_q.krow, 2) == tag_q.krow);

endmodule

// ==== hdl/conv_pkg.sv ====
package conv_pkg;

    localparam int KERNEL       = 7;
    localparam int PIX_PER_WORD = 4;
    localparam int ADDR_W       = 16;
    localparam int QUANT_SHIFT  = 16;

    typedef logic signed [7:0] pixel_t;

    // pix[k] is pixel 4c+k, byte 0 is the leftmost
    typedef union packed {
        logic [31:0]                   raw;
        pixel_t [PIX_PER_WORD-1:0]     pix;
    } act_word_u;

    typedef logic signed [31:0] psum_t;

    typedef pixel_t [KERNEL-1:0] kernel_row_t; // element k is column k

    typedef struct packed {
        logic [ADDR_W-1:0] act_base;
        logic [ADDR_W-1:0] weight_base;
        logic [ADDR_W-1:0] out_base;
        logic [15:0]       scale;
    } conv_cfg_t;

    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
    } mem_rd_t;

    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        act_word_u         data;
    } out_wr_t;

    typedef struct packed {
        logic              valid;
        logic              pad;      // zero slot, no read issued
        logic [1:0]        slot;     // left, centre, right
        logic [2:0]        krow;
        logic              last_row;
        logic [ADDR_W-1:0] out_addr;
    } row_tag_t;

    typedef struct packed {
        logic       valid;
        logic [2:0] krow;
    } wt_tag_t;

endpackage
